// ==== hw/vc_noc_pkg.sv ====
// shared definitions for the virtual-channel output port
// direction enum, port and VC counts, buffer depth
// vector typedefs for VC ids, credit counters, payloads and input vectors
// packed structs for input requests, link flits, credits and VC proposals

package vc_noc_pkg;

  // port and channel counts
  localparam int NUM_INPUTS = 5;
  localparam int NUM_VC     = 4;
  localparam int VC_DEPTH   = 2;

  // derived widths
  localparam int ROUTE_W    = 3;
  localparam int VC_ID_W    = $clog2(NUM_VC);
  localparam int CNT_W      = $clog2(VC_DEPTH + 1);
  localparam int IN_IDX_W   = $clog2(NUM_INPUTS);
  localparam int PAYLOAD_W  = 32;

  // next-hop direction, carried as look-ahead route
  typedef enum logic [ROUTE_W-1:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_direction_e;

  typedef logic [VC_ID_W-1:0]    vc_id_t;
  typedef logic [CNT_W-1:0]      credit_cnt_t;
  typedef logic [PAYLOAD_W-1:0]  payload_t;
  typedef logic [NUM_INPUTS-1:0] in_oh_t;
  typedef logic [IN_IDX_W-1:0]   in_idx_t;

  // one input's offer, already routed upstream
  typedef struct packed {
    logic             valid;
    route_direction_e la_route;
    payload_t         payload;
  } in_req_t;

  typedef struct packed {
    logic             valid;
    vc_id_t           vc_id;
    route_direction_e la_route;
    payload_t         payload;
  } out_flit_t;

  typedef struct packed {
    logic   valid;
    vc_id_t vc_id;
  } credit_t;

  // per next-hop slot: a VC that still has credit
  typedef struct packed {
    logic   valid;
    vc_id_t vc_id;
  } vc_prop_t;

endpackage

// ==== hw/vc_sa_global.sv ====
// round-robin switch allocator for one output port
// picks the first requesting input at or after the pointer
// grant is qualified by VC acceptance, pointer advances only on a grant

`timescale 1ns/10ps

module vc_sa_global (
  input  logic                clk_i,
  input  logic                reset_i,
  input  vc_noc_pkg::in_oh_t  req_v_i,
  input  logic                accept_i,
  output vc_noc_pkg::in_oh_t  winner_oh_o,
  output vc_noc_pkg::in_oh_t  gnt_oh_o
);

  import vc_noc_pkg::*;

  in_idx_t ptr_q;
  in_idx_t winner_idx;
  in_oh_t  winner_oh;
  logic    found;

  // scan inputs starting at the pointer, wrapping around
  always_comb begin
    int unsigned idx;
    winner_oh  = '0;
    winner_idx = '0;
    found      = 1'b0;
    for (int off = 0; off < NUM_INPUTS; off++) begin
      idx = (int'(ptr_q) + off) % NUM_INPUTS;
      if (!found && req_v_i[idx]) begin
        found          = 1'b1;
        winner_oh[idx] = 1'b1;
        winner_idx     = in_idx_t'(idx);
      end
    end
  end

  assign winner_oh_o = winner_oh;

  // only a winner that found a VC is granted
  assign gnt_oh_o = (found && accept_i) ? winner_oh : '0;

  // pointer moves one past the granted input
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (found && accept_i) begin
      if (winner_idx == in_idx_t'(NUM_INPUTS - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= winner_idx + 1'b1;
      end
    end
  end

endmodule

// ==== hw/vc_selection.sv ====
// downstream VC credit tracking and per-direction VC proposals
// one counter per downstream VC, loaded with the buffer depth on reset
// slot d proposes VC d when it has credit, else the lowest VC with credit

`timescale 1ns/10ps

module vc_selection (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  dec_v_i,
  input  vc_noc_pkg::vc_id_t    dec_id_i,
  input  vc_noc_pkg::credit_t   credit_i,
  output vc_noc_pkg::vc_prop_t [vc_noc_pkg::NUM_VC-1:0] prop_o
);

  import vc_noc_pkg::*;

  credit_cnt_t [NUM_VC-1:0] cnt_q;
  credit_cnt_t [NUM_VC-1:0] cnt_d;
  logic        [NUM_VC-1:0] has_credit;
  logic                     lowest_v;
  vc_id_t                   lowest_id;

  // next counter values
  // a grant and a returned credit on the same VC cancel out
  always_comb begin
    logic inc;
    logic dec;
    for (int v = 0; v < NUM_VC; v++) begin
      inc = credit_i.valid && (credit_i.vc_id == vc_id_t'(v));
      dec = dec_v_i && (dec_id_i == vc_id_t'(v));
      cnt_d[v] = cnt_q[v];
      if (inc && !dec) begin
        cnt_d[v] = cnt_q[v] + 1'b1;
      end else if (dec && !inc) begin
        cnt_d[v] = cnt_q[v] - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int v = 0; v < NUM_VC; v++) begin
        cnt_q[v] <= credit_cnt_t'(VC_DEPTH);
      end
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_comb begin
    for (int v = 0; v < NUM_VC; v++) begin
      has_credit[v] = (cnt_q[v] != '0);
    end
  end

  // fallback choice, walking down so the lowest index wins
  always_comb begin
    lowest_v  = 1'b0;
    lowest_id = '0;
    for (int v = NUM_VC - 1; v >= 0; v--) begin
      if (has_credit[v]) begin
        lowest_v  = 1'b1;
        lowest_id = vc_id_t'(v);
      end
    end
  end

  // preferred VC first, otherwise fall back
  always_comb begin
    for (int d = 0; d < NUM_VC; d++) begin
      if (has_credit[d]) begin
        prop_o[d].valid = 1'b1;
        prop_o[d].vc_id = vc_id_t'(d);
      end else begin
        prop_o[d].valid = lowest_v;
        prop_o[d].vc_id = lowest_id;
      end
    end
  end

endmodule

// ==== hw/vc_assignment.sv ====
// VC assignment after switch allocation
// muxes the winner's look-ahead route and maps it onto a proposal slot
// slot numbering follows XY routing, so only reachable next hops get a slot

`timescale 1ns/10ps

module vc_assignment #(
  parameter vc_noc_pkg::route_direction_e OutputId = vc_noc_pkg::East
) (
  input  vc_noc_pkg::in_oh_t                                      winner_oh_i,
  input  vc_noc_pkg::route_direction_e [vc_noc_pkg::NUM_INPUTS-1:0] la_route_i,
  input  vc_noc_pkg::vc_prop_t [vc_noc_pkg::NUM_VC-1:0]           prop_i,
  output logic                                                    assign_v_o,
  output vc_noc_pkg::vc_id_t                                      assign_id_o,
  output vc_noc_pkg::route_direction_e                            la_route_sel_o
);

  import vc_noc_pkg::*;

  logic [ROUTE_W-1:0] sel_raw;
  route_direction_e   la_route_sel;
  vc_id_t             slot;
  logic               slot_ok;

  // one-hot select of the winner's route
  always_comb begin
    sel_raw = '0;
    for (int i = 0; i < NUM_INPUTS; i++) begin
      if (winner_oh_i[i]) begin
        sel_raw = sel_raw | la_route_i[i];
      end
    end
    la_route_sel = route_direction_e'(sel_raw);
  end

  assign la_route_sel_o = la_route_sel;

  // route to slot mapping, depends on which side this port faces
  if (OutputId == East) begin : gen_map_east
    always_comb begin
      slot_ok = 1'b1;
      unique case (la_route_sel)
        North:   slot = vc_id_t'(0);
        East:    slot = vc_id_t'(1);
        South:   slot = vc_id_t'(2);
        Eject:   slot = vc_id_t'(3);
        // a U-turn back west is not a legal XY hop
        default: begin
          slot    = '0;
          slot_ok = 1'b0;
        end
      endcase
    end
  end else if (OutputId == West) begin : gen_map_west
    always_comb begin
      slot_ok = 1'b1;
      unique case (la_route_sel)
        North:   slot = vc_id_t'(0);
        South:   slot = vc_id_t'(1);
        West:    slot = vc_id_t'(2);
        Eject:   slot = vc_id_t'(3);
        default: begin
          slot    = '0;
          slot_ok = 1'b0;
        end
      endcase
    end
  end else if (OutputId == North || OutputId == South) begin : gen_map_ns
    // y-direction flits only go straight on or eject
    always_comb begin
      slot    = '0;
      slot_ok = 1'b0;
      if (la_route_sel == OutputId) begin
        slot    = vc_id_t'(0);
        slot_ok = 1'b1;
      end else if (la_route_sel == Eject) begin
        slot    = vc_id_t'(1);
        slot_ok = 1'b1;
      end
    end
  end else begin : gen_map_local
    // local ports have a single VC
    assign slot    = '0;
    assign slot_ok = 1'b1;
  end

  assign assign_v_o  = (|winner_oh_i) && slot_ok && prop_i[slot].valid;
  assign assign_id_o = prop_i[slot].vc_id;

endmodule

// ==== hw/vc_switch_column.sv ====
// crossbar column of one output port
// one-hot payload select and the registered link flit

`timescale 1ns/10ps

module vc_switch_column (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  input  vc_noc_pkg::in_oh_t                                sel_oh_i,
  input  vc_noc_pkg::payload_t [vc_noc_pkg::NUM_INPUTS-1:0] payload_i,
  input  logic                                              assign_v_i,
  input  vc_noc_pkg::vc_id_t                                assign_id_i,
  input  vc_noc_pkg::route_direction_e                      la_route_i,
  output vc_noc_pkg::out_flit_t                             out_flit_o
);

  import vc_noc_pkg::*;

  payload_t         payload_sel;
  logic             valid_q;
  vc_id_t           vc_id_q;
  route_direction_e la_route_q;
  payload_t         payload_q;

  always_comb begin
    payload_sel = '0;
    for (int i = 0; i < NUM_INPUTS; i++) begin
      if (sel_oh_i[i]) begin
        payload_sel = payload_sel | payload_i[i];
      end
    end
  end

  // valid lasts one cycle per grant
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= assign_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (assign_v_i) begin
      vc_id_q    <= assign_id_i;
      la_route_q <= la_route_i;
      payload_q  <= payload_sel;
    end
  end

  assign out_flit_o.valid    = valid_q;
  assign out_flit_o.vc_id    = vc_id_q;
  assign out_flit_o.la_route = la_route_q;
  assign out_flit_o.payload  = payload_q;

endmodule

// ==== hw/vc_output_port.sv ====
// one output port of a virtual-channel mesh router
// switch allocator, VC selection, VC assignment and switch column
// grant is combinational, the link flit follows one cycle later

`timescale 1ns/10ps

module vc_output_port #(
  parameter vc_noc_pkg::route_direction_e OutputId = vc_noc_pkg::East
) (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  vc_noc_pkg::in_req_t [vc_noc_pkg::NUM_INPUTS-1:0] in_req_i,
  output vc_noc_pkg::in_oh_t                               in_gnt_o,
  output vc_noc_pkg::out_flit_t                            out_flit_o,
  input  vc_noc_pkg::credit_t                              credit_i
);

  import vc_noc_pkg::*;

  in_oh_t                             req_v;
  route_direction_e [NUM_INPUTS-1:0]  la_route;
  payload_t [NUM_INPUTS-1:0]          payload;
  in_oh_t                             winner_oh;
  vc_prop_t [NUM_VC-1:0]              prop;
  logic                               assign_v;
  vc_id_t                             assign_id;
  route_direction_e                   la_route_sel;

  // split the request structs into per-field vectors
  for (genvar i = 0; i < NUM_INPUTS; i++) begin : gen_unpack
    assign req_v[i]    = in_req_i[i].valid;
    assign la_route[i] = in_req_i[i].la_route;
    assign payload[i]  = in_req_i[i].payload;
  end

  vc_sa_global u_vc_sa_global (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (req_v),
    .accept_i    (assign_v),
    .winner_oh_o (winner_oh),
    .gnt_oh_o    (in_gnt_o)
  );

  vc_selection u_vc_selection (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .dec_v_i  (assign_v),
    .dec_id_i (assign_id),
    .credit_i (credit_i),
    .prop_o   (prop)
  );

  vc_assignment #(
    .OutputId (OutputId)
  ) u_vc_assignment (
    .winner_oh_i    (winner_oh),
    .la_route_i     (la_route),
    .prop_i         (prop),
    .assign_v_o     (assign_v),
    .assign_id_o    (assign_id),
    .la_route_sel_o (la_route_sel)
  );

  vc_switch_column u_vc_switch_column (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .sel_oh_i    (winner_oh),
    .payload_i   (payload),
    .assign_v_i  (assign_v),
    .assign_id_i (assign_id),
    .la_route_i  (la_route_sel),
    .out_flit_o  (out_flit_o)
  );

endmodule

// ==== verif/vc_clk_gen.sv ====
// testbench clock and reset
// 100 ns clock, synchronous reset held for three rising edges

`timescale 1ns/10ps

module vc_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  localparam int HALF_PERIOD_NS = 50;
  localparam int RESET_CYCLES   = 3;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // released right after a rising edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== verif/vc_output_port_props.sv ====
// concurrent properties of the VC output port, bound into the top level
// grant vector shape, link flit after a grant, no U-turn routes on the link

`timescale 1ns/10ps

module vc_output_port_props #(
  parameter vc_noc_pkg::route_direction_e OutputId = vc_noc_pkg::East
) (
  input logic                  clk_i,
  input logic                  reset_i,
  input vc_noc_pkg::in_oh_t    in_gnt_i,
  input vc_noc_pkg::out_flit_t out_flit_i
);

  import vc_noc_pkg::*;

  function automatic route_direction_e opposite_of(route_direction_e dir);
    case (dir)
      North:   return South;
      South:   return North;
      East:    return West;
      West:    return East;
      default: return Eject;
    endcase
  endfunction

  localparam route_direction_e BACK_ROUTE = opposite_of(OutputId);

  // failures seen so far, read by the testbench at the end of the run
  int fail_cnt = 0;

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(in_gnt_i))
    else begin
      $error("more than one input granted in one cycle");
      fail_cnt = fail_cnt + 1;
    end

  a_flit_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    out_flit_i.valid |-> $past(|in_gnt_i))
    else begin
      $error("link flit without a grant in the previous cycle");
      fail_cnt = fail_cnt + 1;
    end

  // a local port has no opposite side
  a_no_u_turn: assert property (@(posedge clk_i) disable iff (reset_i)
    out_flit_i.valid |-> (OutputId == Eject || out_flit_i.la_route != BACK_ROUTE))
    else begin
      $error("link flit routed back the way it came");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind vc_output_port vc_output_port_props #(
  .OutputId (OutputId)
) u_vc_output_port_props (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .in_gnt_i   (in_gnt_o),
  .out_flit_i (out_flit_o)
);

// ==== verif/tb_vc_output_port.sv ====
// testbench of the VC output port, East side
// reference model of the credit counters and the round-robin pointer
// directed tests for reset, VC mapping, round-robin, exhaustion and credit return

`timescale 1ns/10ps

module tb_vc_output_port;

  import vc_noc_pkg::*;

  localparam int CLK_PERIOD_NS = 100;
  localparam int RR_GRANTS     = 20;
  localparam int DRAIN_CYCLES  = 2*NUM_VC + 5;
  // reset, mapping, round-robin, exhaustion and credit return, in cycles
  localparam int TEST_CYCLES   = 4 + 3*NUM_INPUTS + (RR_GRANTS + 2) + DRAIN_CYCLES + 3;
  localparam int MARGIN_CYCLES = 40;

  logic                     clk;
  logic                     reset;
  in_req_t [NUM_INPUTS-1:0] in_req;
  in_oh_t                   in_gnt;
  out_flit_t                out_flit;
  credit_t                  credit;

  int        model_cnt [NUM_VC];
  int        model_ptr;
  out_flit_t exp_flit;

  vc_clk_gen u_vc_clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  vc_output_port #(
    .OutputId (East)
  ) u_vc_output_port (
    .clk_i      (clk),
    .reset_i    (reset),
    .in_req_i   (in_req),
    .in_gnt_o   (in_gnt),
    .out_flit_o (out_flit),
    .credit_i   (credit)
  );

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    assert (got == exp) else begin
      $display("FAIL t=%0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1, "mismatch, run stopped");
    end
  endtask

  // proposal slot for an East output, -1 for a U-turn
  function automatic int route_slot(route_direction_e route);
    case (route)
      North:   return 0;
      East:    return 1;
      South:   return 2;
      Eject:   return 3;
      default: return -1;
    endcase
  endfunction

  // preferred VC if it has credit, else the lowest one that does
  function automatic int pick_vc(int slot);
    int vc;
    vc = -1;
    if (slot >= 0 && model_cnt[slot] > 0) begin
      vc = slot;
    end else if (slot >= 0) begin
      for (int v = NUM_VC - 1; v >= 0; v--) begin
        if (model_cnt[v] > 0) begin
          vc = v;
        end
      end
    end
    return vc;
  endfunction

  task automatic offer_flit(int idx, route_direction_e route);
    in_req[idx].valid    <= 1'b1;
    in_req[idx].la_route <= route;
    in_req[idx].payload  <= $urandom;
  endtask

  task automatic set_credit(logic valid, vc_id_t vc);
    credit.valid <= valid;
    credit.vc_id <= vc;
  endtask

  // sample at the falling edge, compare, then step the model over the next rising edge
  task automatic run_cycle(output in_oh_t gnt_seen, output out_flit_t flit_seen);
    int        win;
    int        vc;
    in_oh_t    exp_gnt;
    out_flit_t nxt;
    @(negedge clk);
    win     = -1;
    vc      = -1;
    exp_gnt = '0;
    nxt     = '0;
    for (int off = NUM_INPUTS - 1; off >= 0; off--) begin
      if (in_req[(model_ptr + off) % NUM_INPUTS].valid) begin
        win = (model_ptr + off) % NUM_INPUTS;
      end
    end
    if (win >= 0) begin
      vc = pick_vc(route_slot(in_req[win].la_route));
    end
    if (vc >= 0) begin
      exp_gnt[win] = 1'b1;
      nxt.valid    = 1'b1;
      nxt.vc_id    = vc_id_t'(vc);
      nxt.la_route = in_req[win].la_route;
      nxt.payload  = in_req[win].payload;
      model_cnt[vc] = model_cnt[vc] - 1;
      model_ptr     = (win + 1) % NUM_INPUTS;
    end
    if (credit.valid) begin
      model_cnt[credit.vc_id] = model_cnt[credit.vc_id] + 1;
    end
    check_value("in_gnt_o", 64'(in_gnt), 64'(exp_gnt));
    check_value("out_flit_o.valid", 64'(out_flit.valid), 64'(exp_flit.valid));
    if (exp_flit.valid) begin
      check_value("out_flit_o", 64'(out_flit), 64'(exp_flit));
    end
    exp_flit  = nxt;
    gnt_seen  = in_gnt;
    flit_seen = out_flit;
    @(posedge clk);
  endtask

  task automatic reset_state();
    @(negedge clk);
    while (reset) begin
      check_value("in_gnt_o", 64'(in_gnt), 64'(0));
      check_value("out_flit_o.valid", 64'(out_flit.valid), 64'(0));
      @(negedge clk);
    end
    for (int v = 0; v < NUM_VC; v++) begin
      model_cnt[v] = VC_DEPTH;
    end
    model_ptr = 0;
    exp_flit  = '0;
    @(posedge clk);
  endtask

  // one request at a time, the link flit shows the preferred VC a cycle later
  task automatic map_routes();
    route_direction_e routes [NUM_INPUTS];
    in_oh_t           gnt;
    out_flit_t        flit;
    routes = '{North, East, South, Eject, East};
    for (int i = 0; i < NUM_INPUTS; i++) begin
      offer_flit(i, routes[i]);
      run_cycle(gnt, flit);
      check_value("in_gnt_o", 64'(gnt), 64'(1 << i));
      in_req[i].valid <= 1'b0;
      run_cycle(gnt, flit);
      check_value("out_flit_o.vc_id", 64'(flit.vc_id), 64'(route_slot(routes[i])));
      set_credit(1'b1, flit.vc_id);
      run_cycle(gnt, flit);
      set_credit(1'b0, '0);
    end
  endtask

  task automatic rotate_grants();
    route_direction_e routes [NUM_INPUTS];
    int               count [NUM_INPUTS];
    in_oh_t           gnt;
    out_flit_t        flit;
    routes = '{East, North, Eject, South, East};
    for (int i = 0; i < NUM_INPUTS; i++) begin
      count[i] = 0;
      offer_flit(i, routes[i]);
    end
    for (int g = 0; g < RR_GRANTS; g++) begin
      run_cycle(gnt, flit);
      check_value("in_gnt_o", 64'(gnt), 64'(1 << (g % NUM_INPUTS)));
      for (int i = 0; i < NUM_INPUTS; i++) begin
        if (gnt[i]) begin
          count[i] = count[i] + 1;
          offer_flit(i, routes[i]);
        end
      end
      // each link flit hands its credit straight back
      set_credit(flit.valid, flit.vc_id);
    end
    for (int i = 0; i < NUM_INPUTS; i++) begin
      check_value("grants per input", 64'(count[i]), 64'(RR_GRANTS / NUM_INPUTS));
      in_req[i].valid <= 1'b0;
    end
    run_cycle(gnt, flit);
    set_credit(flit.valid, flit.vc_id);
    run_cycle(gnt, flit);
    set_credit(1'b0, '0);
  endtask

  // East flits without returns: VC 1 twice, then lowest VCs with credit
  task automatic drain_credits();
    int        exp_vc [2*NUM_VC];
    int        grants;
    int        flits;
    in_oh_t    gnt;
    out_flit_t flit;
    exp_vc = '{1, 1, 0, 0, 2, 2, 3, 3};
    grants = 0;
    flits  = 0;
    offer_flit(1, East);
    for (int c = 0; c < DRAIN_CYCLES; c++) begin
      run_cycle(gnt, flit);
      if (flit.valid) begin
        check_value("link flit count", 64'(flits < 2*NUM_VC), 64'(1));
        check_value("out_flit_o.vc_id", 64'(flit.vc_id), 64'(exp_vc[flits]));
        flits = flits + 1;
      end
      if (gnt[1]) begin
        grants = grants + 1;
        offer_flit(1, East);
      end
    end
    check_value("grants before exhaustion", 64'(grants), 64'(2*NUM_VC));
    check_value("link flits before exhaustion", 64'(flits), 64'(2*NUM_VC));
  endtask

  task automatic refill_credit();
    in_oh_t    gnt;
    out_flit_t flit;
    payload_t  sent;
    set_credit(1'b1, vc_id_t'(1));
    run_cycle(gnt, flit);
    check_value("in_gnt_o", 64'(gnt), 64'(0));
    set_credit(1'b0, '0);
    run_cycle(gnt, flit);
    check_value("in_gnt_o", 64'(gnt), 64'(1 << 1));
    sent = in_req[1].payload;
    in_req[1].valid <= 1'b0;
    run_cycle(gnt, flit);
    check_value("out_flit_o.vc_id", 64'(flit.vc_id), 64'(1));
    check_value("out_flit_o.payload", 64'(flit.payload), 64'(sent));
  endtask

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS);
    $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    in_req   = '0;
    credit   = '0;
    exp_flit = '0;
    void'($urandom(32'h31bb_fcff));
    reset_state();
    map_routes();
    rotate_grants();
    drain_credits();
    refill_credit();
    if (u_vc_output_port.u_vc_output_port_props.fail_cnt == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("bound assertions failed during the run");
      $display("Test FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// ==== sim.f ====
hw/vc_noc_pkg.sv
hw/vc_sa_global.sv
hw/vc_selection.sv
hw/vc_assignment.sv
hw/vc_switch_column.sv
hw/vc_output_port.sv
verif/vc_clk_gen.sv
verif/vc_output_port_props.sv
verif/tb_vc_output_port.sv

// ==== Makefile ====
# Verilator lint and simulation of the VC output port

VERILATOR  ?= verilator
TOP        := tb_vc_output_port
FILELIST   := sim.f
OBJ_DIR    := obj_dir
FLAGS      := --timing --assert
LINT_FLAGS := --lint-only $(FLAGS)
SIM_FLAGS  := --binary $(FLAGS) --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary exits non-zero when the testbench stops with $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
